/* logic/txHdrPkg.sv */
package txHdrPkg;

    // Header and length field widths
    localparam int hdrWidthC       = 128;
    localparam int lenWidthC       = 10;
    localparam int nonpayWidthC    = 3;
    localparam int packetLenWidthC = 11;

    typedef enum logic [1:0] {
        opMemRead    = 2'd0,
        opMemWrite   = 2'd1,
        opCompletion = 2'd2
    } txOpT;

    // Length of 0 means 1024 dwords
    typedef struct packed {
        txOpT                 op;
        logic [63:0]          addr;
        logic [lenWidthC-1:0] len;
        logic [7:0]           tag;
    } txReqT;

    // Dword 0 sits in hdr[31:0], dword 3 in hdr[127:96]
    typedef struct packed {
        logic [hdrWidthC-1:0]       hdr;
        logic [nonpayWidthC-1:0]    nonpayLen;
        logic [packetLenWidthC-1:0] packetLen;
        logic [lenWidthC-1:0]       payloadLen;
        logic                       noPayload;
    } txHdrT;

endpackage

/* logic/requesterConfig.sv */
`timescale 1ns/100ps

module requesterConfig (
    input  logic        clk,
    input  logic        rstN,
    input  logic        cfgWrite,
    input  logic [15:0] cfgData,
    output logic [15:0] requesterId
);

    logic [15:0] idQ;

    // Bus, device and function number of this requester
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idQ <= '0;
        end else if (cfgWrite) begin
            idQ <= cfgData;
        end
    end

    assign requesterId = idQ;

endmodule

/* logic/pipelineStage.sv */
`timescale 1ns/100ps

module pipelineStage #(
    parameter int depth = 1
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    input  txHdrPkg::txHdrT inData,
    output logic            inReady,
    output logic            outValid,
    output txHdrPkg::txHdrT outData,
    input  logic            outReady
);
    import txHdrPkg::*;

    generate
        if (depth != 0) begin : gSlice
            logic  validQ;
            txHdrT dataQ;

            // Take a new item when empty or while draining
            assign inReady = !validQ || outReady;

            always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                    validQ <= 1'b0;
                end else if (inReady) begin
                    validQ <= inValid;
                end
            end

            always_ff @(posedge clk) begin
                if (inValid && inReady) begin
                    dataQ <= inData;
                end
            end

            assign outValid = validQ;
            assign outData  = dataQ;
        end else begin : gBypass
            assign inReady  = outReady;
            assign outValid = inValid;
            assign outData  = inData;
        end
    endgenerate

    // Holds valid until the consumer takes it, also in bypass mode
    validHeld: assert property (
        @(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid
    );

endmodule

/* logic/hdrFifo.sv */
`timescale 1ns/100ps

module hdrFifo #(
    parameter int depthPackets = 10
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            wrValid,
    input  txHdrPkg::txHdrT wrData,
    output logic            wrReady,
    output logic            rdValid,
    output txHdrPkg::txHdrT rdData,
    input  logic            rdReady
);
    import txHdrPkg::*;

    localparam int ptrW   = (depthPackets > 1) ? $clog2(depthPackets) : 1;
    localparam int countW = $clog2(depthPackets + 1);

    txHdrT             mem [depthPackets];
    logic [ptrW-1:0]   wrPtr;
    logic [ptrW-1:0]   rdPtr;
    logic [countW-1:0] count;
    logic              full;
    logic              wrEn;
    logic              rdEn;

    assign full    = (count == countW'(depthPackets));
    assign rdValid = (count != '0);
    assign rdData  = mem[rdPtr];

    // A full FIFO still takes a write when a read frees a slot
    assign wrReady = !full || rdReady;
    assign wrEn    = wrValid && wrReady;
    assign rdEn    = rdValid && rdReady;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrPtr] <= wrData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= (wrPtr == ptrW'(depthPackets - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (rdEn) begin
                rdPtr <= (rdPtr == ptrW'(depthPackets - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    noOverflow: assert property (
        @(posedge clk) disable iff (!rstN)
        wrEn && full |-> rdEn
    );

    countBound: assert property (
        @(posedge clk) disable iff (!rstN)
        count <= countW'(depthPackets)
    );

endmodule

/* logic/txHdrFifo.sv */
`timescale 1ns/100ps

module txHdrFifo #(
    parameter int depthPackets   = 10,
    parameter int pipelineInput  = 1,
    parameter int pipelineOutput = 1
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            wrValid,
    input  txHdrPkg::txHdrT wrHdr,
    output logic            wrReady,
    output logic            rdValid,
    output txHdrPkg::txHdrT rdHdr,
    input  logic            rdReady
);
    import txHdrPkg::*;

    logic  fifoWrValid;
    logic  fifoWrReady;
    txHdrT fifoWrData;
    logic  fifoRdValid;
    logic  fifoRdReady;
    txHdrT fifoRdData;

    pipelineStage #(.depth(pipelineInput != 0 ? 1 : 0)) inputStage (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (wrValid),
        .inData   (wrHdr),
        .inReady  (wrReady),
        .outValid (fifoWrValid),
        .outData  (fifoWrData),
        .outReady (fifoWrReady)
    );

    hdrFifo #(.depthPackets(depthPackets)) fifoInst (
        .clk     (clk),
        .rstN    (rstN),
        .wrValid (fifoWrValid),
        .wrData  (fifoWrData),
        .wrReady (fifoWrReady),
        .rdValid (fifoRdValid),
        .rdData  (fifoRdData),
        .rdReady (fifoRdReady)
    );

    pipelineStage #(.depth(pipelineOutput != 0 ? 1 : 0)) outputStage (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (fifoRdValid),
        .inData   (fifoRdData),
        .inReady  (fifoRdReady),
        .outValid (rdValid),
        .outData  (rdHdr),
        .outReady (rdReady)
    );

endmodule

/* logic/txHdrBuilder.sv */
`timescale 1ns/100ps

module txHdrBuilder (
    input  logic            clk,
    input  logic            rstN,
    input  logic            reqValid,
    input  txHdrPkg::txReqT req,
    output logic            reqReady,
    input  logic [15:0]     requesterId,
    output logic            bldValid,
    output txHdrPkg::txHdrT bld,
    input  logic            bldReady
);
    import txHdrPkg::*;

    logic                       isRead;
    logic                       fourDw;
    logic [7:0]                 fmtCode;
    logic [31:0]                dw0;
    logic [31:0]                dw1;
    logic [31:0]                dw2;
    logic [31:0]                dw3;
    logic [packetLenWidthC-1:0] payloadDw;
    txHdrT                      nextHdr;
    logic                       validQ;
    txHdrT                      bldQ;

    // Decode opcode and address width
    always_comb begin
        isRead = (req.op == opMemRead);
        fourDw = (req.addr[63:32] != 32'd0) && (req.op != opCompletion);
        case (req.op)
            opMemRead:    fmtCode = fourDw ? 8'h20 : 8'h00;
            opMemWrite:   fmtCode = fourDw ? 8'h60 : 8'h40;
            opCompletion: fmtCode = 8'h4A;
            default:      fmtCode = 8'h00;
        endcase
    end

    always_comb begin
        dw0 = {fmtCode, 14'd0, req.len};
        dw1 = {requesterId, req.tag, 8'hFF};
        if (fourDw) begin
            dw2 = req.addr[63:32];
            dw3 = {req.addr[31:2], 2'b00};
        end else begin
            dw2 = req.addr[31:0];
            dw3 = 32'd0;
        end

        // Zero length field stands for 1024 dwords
        if (isRead) begin
            payloadDw = '0;
        end else if (req.len == '0) begin
            payloadDw = packetLenWidthC'(1024);
        end else begin
            payloadDw = packetLenWidthC'(req.len);
        end

        nextHdr.hdr        = {dw3, dw2, dw1, dw0};
        nextHdr.nonpayLen  = fourDw ? nonpayWidthC'(4) : nonpayWidthC'(3);
        nextHdr.packetLen  = payloadDw + packetLenWidthC'(nextHdr.nonpayLen);
        nextHdr.payloadLen = isRead ? '0 : req.len;
        nextHdr.noPayload  = isRead;
    end

    assign reqReady = !validQ || bldReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (reqReady) begin
            validQ <= reqValid;
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            bldQ <= nextHdr;
        end
    end

    assign bldValid = validQ;
    assign bld      = bldQ;

    bldHeld: assert property (
        @(posedge clk) disable iff (!rstN)
        bldValid && !bldReady |=> bldValid && $stable(bld)
    );

endmodule

/* logic/txHdrPath.sv */
`timescale 1ns/100ps

module txHdrPath #(
    parameter int depthPackets   = 10,
    parameter int pipelineInput  = 1,
    parameter int pipelineOutput = 1
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            cfgWrite,
    input  logic [15:0]     cfgData,
    input  logic            reqValid,
    input  txHdrPkg::txReqT req,
    output logic            reqReady,
    output logic            hdrValid,
    output txHdrPkg::txHdrT hdrOut,
    input  logic            hdrReady
);
    import txHdrPkg::*;

    logic [15:0] requesterId;
    logic        bldValid;
    logic        bldReady;
    txHdrT       bld;

    requesterConfig cfgInst (
        .clk         (clk),
        .rstN        (rstN),
        .cfgWrite    (cfgWrite),
        .cfgData     (cfgData),
        .requesterId (requesterId)
    );

    txHdrBuilder builderInst (
        .clk         (clk),
        .rstN        (rstN),
        .reqValid    (reqValid),
        .req         (req),
        .reqReady    (reqReady),
        .requesterId (requesterId),
        .bldValid    (bldValid),
        .bld         (bld),
        .bldReady    (bldReady)
    );

    txHdrFifo #(
        .depthPackets   (depthPackets),
        .pipelineInput  (pipelineInput),
        .pipelineOutput (pipelineOutput)
    ) hdrFifoInst (
        .clk     (clk),
        .rstN    (rstN),
        .wrValid (bldValid),
        .wrHdr   (bld),
        .wrReady (bldReady),
        .rdValid (hdrValid),
        .rdHdr   (hdrOut),
        .rdReady (hdrReady)
    );

endmodule

/* bench/txHdrModel.svh */
`ifndef TX_HDR_MODEL_SVH
`define TX_HDR_MODEL_SVH

// Expected headers in request order
txHdrT       expQ[$];
logic [15:0] modelId = 16'h0000;

function automatic txHdrT expectedHeader(input txReqT r, input logic [15:0] id);
    txHdrT      e;
    logic       isRead;
    logic       wide;
    logic [7:0] fmt;
    int         payloadDw;
    isRead = (r.op == opMemRead);
    // Completions stay at 3 dwords whatever the address
    wide = (r.op != opCompletion) && (r.addr[63:32] != 32'h0);
    case (r.op)
        opMemRead:  fmt = wide ? 8'h20 : 8'h00;
        opMemWrite: fmt = wide ? 8'h60 : 8'h40;
        default:    fmt = 8'h4A;
    endcase
    e.hdr = '0;
    e.hdr[31:24] = fmt;
    e.hdr[9:0] = r.len;
    e.hdr[63:48] = id;
    e.hdr[47:40] = r.tag;
    e.hdr[39:32] = 8'hFF;
    if (wide) begin
        e.hdr[95:64] = r.addr[63:32];
        e.hdr[127:96] = r.addr[31:0] & 32'hFFFF_FFFC;
    end else begin
        e.hdr[95:64] = r.addr[31:0];
    end
    payloadDw = isRead ? 0 : ((r.len == '0) ? 1024 : int'(r.len));
    e.nonpayLen = wide ? 3'd4 : 3'd3;
    e.packetLen = 11'(payloadDw + (wide ? 4 : 3));
    e.payloadLen = isRead ? 10'd0 : r.len;
    e.noPayload = isRead;
    return e;
endfunction

`endif

/* bench/txHdrPathTb.sv */
`timescale 1ns/100ps

module txHdrPathTb;
    import txHdrPkg::*;

    localparam int depthC       = 10;
    localparam int numRandomC   = 300;
    localparam int numCfgC      = 8;
    localparam int maxFillC     = 20;
    localparam int numRequestsC = numRandomC + numCfgC + maxFillC;
    localparam int timeoutC     = 20 * numRequestsC * 10;
    localparam int drainCyclesC = 20 * (depthC + 3);
    localparam int readyRandomC = 0;
    localparam int readyLowC    = 1;

    logic        clk = 1'b0;
    logic        rstN;
    logic        cfgWrite;
    logic [15:0] cfgData;
    logic        reqValid;
    txReqT       req;
    logic        reqReady;
    logic        hdrValid;
    txHdrT       hdrOut;
    logic        hdrReady = 1'b0;
    logic        nextReady = 1'b0;
    int          readyMode = readyRandomC;
    int          seed = 32'h8c06_9c12;
    // Separate stream for hdrReady
    int          readySeed = 32'h8c06_9c12 ^ 32'h0000_ffff;
    int          checkErrors = 0;
    int          flowErrors = 0;
    int          checkCount = 0;
    int          pushCount = 0;

    `include "txHdrModel.svh"

    txHdrPath i_dut (
        .clk      (clk),
        .rstN     (rstN),
        .cfgWrite (cfgWrite),
        .cfgData  (cfgData),
        .reqValid (reqValid),
        .req      (req),
        .reqReady (reqReady),
        .hdrValid (hdrValid),
        .hdrOut   (hdrOut),
        .hdrReady (hdrReady)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        nextReady = ($unsigned($random(readySeed)) % 10) < 7;
        if (readyMode == readyLowC) begin
            nextReady = 1'b0;
        end
    end

    always @(negedge clk) begin
        hdrReady = nextReady;
    end

    task automatic reportMismatch(input string field, input logic [31:0] got,
                                  input logic [31:0] exp);
        checkErrors++;
        $display("[ERROR] %0t: %s is %h, expected %h", $time, field, got, exp);
    endtask

    task automatic checkHeader(input txHdrT got, input txHdrT exp);
        checkCount++;
        for (int i = 0; i < 4; i++) begin
            if (got.hdr[32*i +: 32] !== exp.hdr[32*i +: 32]) begin
                reportMismatch($sformatf("hdr dword %0d", i), got.hdr[32*i +: 32],
                               exp.hdr[32*i +: 32]);
            end
        end
        if (got.nonpayLen !== exp.nonpayLen) begin
            reportMismatch("nonpayLen", 32'(got.nonpayLen), 32'(exp.nonpayLen));
        end
        if (got.packetLen !== exp.packetLen) begin
            reportMismatch("packetLen", 32'(got.packetLen), 32'(exp.packetLen));
        end
        if (got.payloadLen !== exp.payloadLen) begin
            reportMismatch("payloadLen", 32'(got.payloadLen), 32'(exp.payloadLen));
        end
        if (got.noPayload !== exp.noPayload) begin
            reportMismatch("noPayload", 32'(got.noPayload), 32'(exp.noPayload));
        end
    endtask

    // Mid-cycle sample of the transfers at the next rising edge
    always @(negedge clk) begin
        #2;
        if (rstN) begin
            if (reqValid && reqReady) begin
                expQ.push_back(expectedHeader(req, modelId));
                pushCount++;
            end
            if (cfgWrite) begin
                modelId = cfgData;
            end
            if (hdrValid && hdrReady) begin
                if (expQ.size() == 0) begin
                    checkErrors++;
                    $display("Header came out with no request pending at %0t", $time);
                end else begin
                    checkHeader(hdrOut, expQ.pop_front());
                end
            end
        end
    end

    function automatic txReqT randomRequest(input bit high);
        txReqT       r;
        logic [31:0] rnd;
        rnd = $random(seed);
        case (rnd % 3)
            0:       r.op = opMemRead;
            1:       r.op = opMemWrite;
            default: r.op = opCompletion;
        endcase
        r.addr[31:0] = $random(seed);
        rnd = $random(seed);
        r.addr[63:32] = high ? (rnd | 32'h0000_0001) : 32'h0;
        rnd = $random(seed);
        r.tag = rnd[7:0];
        // Zero length is common and stands for 1024 dwords
        r.len = (rnd[15:13] == 3'd0) ? 10'd0 : rnd[25:16];
        return r;
    endfunction

    // Starts on a falling edge and ends on one when taken
    task automatic offerRequest(input txReqT r, input int maxWait, output bit taken);
        int waited;
        waited = 0;
        req = r;
        reqValid = 1'b1;
        #2;
        while (!reqReady && waited < maxWait) begin
            @(negedge clk);
            #2;
            waited++;
        end
        taken = reqReady;
        if (taken) begin
            @(negedge clk);
            reqValid = 1'b0;
        end
    endtask

    task automatic sendRequest(input txReqT r);
        bit taken;
        offerRequest(r, timeoutC, taken);
    endtask

    task automatic writeConfig(input logic [15:0] id);
        cfgWrite = 1'b1;
        cfgData = id;
        @(negedge clk);
        cfgWrite = 1'b0;
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expQ.size() != 0 && waited < drainCyclesC) begin
            @(negedge clk);
            waited++;
        end
        repeat (3) @(negedge clk);
    endtask

    initial begin
        int          accepted;
        bit          taken;
        logic [31:0] rnd;
        rstN = 1'b0;
        cfgWrite = 1'b0;
        cfgData = '0;
        reqValid = 1'b0;
        req = '0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        #2;
        if (hdrValid !== 1'b0 || reqReady !== 1'b1) begin
            flowErrors++;
            $display("[ERROR] %0t: after reset hdrValid %b reqReady %b", $time,
                     hdrValid, reqReady);
        end
        @(negedge clk);

        for (int i = 0; i < numRandomC; i++) begin
            sendRequest(randomRequest(i % 2 == 1));
            rnd = $random(seed);
            repeat (rnd % 3) @(negedge clk);
        end
        waitDrain();

        // Older headers wait in the buffer while the ID changes
        readyMode = readyLowC;
        for (int i = 0; i < numCfgC; i++) begin
            if (i % 2 == 0) begin
                rnd = $random(seed);
                writeConfig(rnd[15:0]);
            end
            sendRequest(randomRequest(i % 4 >= 2));
        end
        readyMode = readyRandomC;
        waitDrain();

        readyMode = readyLowC;
        repeat (2) @(negedge clk);
        accepted = 0;
        taken = 1'b1;
        while (taken && accepted < maxFillC) begin
            offerRequest(randomRequest(accepted % 2 == 1), 6, taken);
            if (taken) begin
                accepted++;
            end
        end
        if (taken) begin
            flowErrors++;
            $display("reqReady never fell with hdrReady held low");
        end
        if (accepted > depthC + 3) begin
            flowErrors++;
            $display("[ERROR] %0t: %0d requests accepted, limit %0d", $time, accepted,
                     depthC + 3);
        end
        readyMode = readyRandomC;
        if (!taken) begin
            @(negedge clk);
            sendRequest(req);
        end
        waitDrain();

        if (expQ.size() != 0 || checkCount != pushCount) begin
            flowErrors++;
            $display("Headers lost: %0d accepted, %0d came out", pushCount, checkCount);
        end
        $display("Headers checked %0d, header errors %0d, flow errors %0d", checkCount,
                 checkErrors, flowErrors);
        if (checkErrors == 0 && flowErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(timeoutC);
        $display("Watchdog expired at %0t, the header path stopped making progress", $time);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* txHdrPath.f */
+incdir+bench
logic/txHdrPkg.sv
logic/requesterConfig.sv
logic/pipelineStage.sv
logic/hdrFifo.sv
logic/txHdrFifo.sv
logic/txHdrBuilder.sv
logic/txHdrPath.sv
bench/txHdrPathTb.sv

/* Makefile */
TOP := txHdrPathTb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): txHdrPath.f logic/*.sv bench/txHdrPathTb.sv bench/txHdrModel.svh
	verilator --binary --timing --assert --top-module $(TOP) -f txHdrPath.f

# The log decides pass or fail, not the simulator exit code
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
